// File: common/pwl_pkg.sv
package pwl_pkg;

	localparam int SAMPLE_W = 16;
	localparam int SEG_W = 3 * SAMPLE_W;

	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic [SAMPLE_W-1:0] slope_t; // two's complement increment per sample.
	typedef logic [SAMPLE_W-1:0] dt_t;
	typedef logic [SEG_W-1:0] seg_word_t;

	// a segment word is start value, slope, duration from the top bit down.
	function automatic sample_t seg_start(input seg_word_t w);
		return w[2*SAMPLE_W +: SAMPLE_W];
	endfunction

	function automatic slope_t seg_slope(input seg_word_t w);
		return w[SAMPLE_W +: SAMPLE_W];
	endfunction

	function automatic dt_t seg_dt(input seg_word_t w);
		return w[0 +: SAMPLE_W];
	endfunction

endpackage

// File: common/wave_mem_if.sv
`timescale 1ns/1ps

interface wave_mem_if #(
	parameter int WAVE_DEPTH = 32
);
	import pwl_pkg::*;

	localparam int AW = $clog2(WAVE_DEPTH);

	logic req; // held until grant.
	logic we;
	logic [AW-1:0] addr;
	seg_word_t wdata;
	logic grant;
	seg_word_t rdata;
	logic rvalid; // one cycle after a granted read.

	modport requester (
		output req, we, addr, wdata,
		input grant, rdata, rvalid
	);

	modport arbiter (
		input req, we, addr, wdata,
		output grant, rdata, rvalid
	);

endinterface

// File: pwl_generator/pwl_generator.sv
`timescale 1ns/1ps

module pwl_generator #(
	parameter int BATCH_SIZE = 4,
	parameter int WAVE_DEPTH = 32
) (
	input logic clk,
	input logic rst,
	input pwl_pkg::seg_word_t dma_data,
	input logic dma_valid,
	input logic dma_last,
	output logic dma_ready,
	input logic run,
	input logic halt,
	input logic dac_rdy,
	output logic rdy_to_run,
	output pwl_pkg::sample_t [BATCH_SIZE-1:0] batch_out,
	output logic valid_batch_out
);
	import pwl_pkg::*;

	localparam int AW = $clog2(WAVE_DEPTH);

	logic ram_en;
	logic ram_we;
	logic [AW-1:0] ram_addr;
	seg_word_t ram_wdata;
	seg_word_t ram_rdata;
	logic [AW:0] seg_count;
	logic wave_loaded;
	logic playing;

	wave_mem_if #(.WAVE_DEPTH(WAVE_DEPTH)) loader_mem ();
	wave_mem_if #(.WAVE_DEPTH(WAVE_DEPTH)) player_mem ();

	wave_loader #(.WAVE_DEPTH(WAVE_DEPTH)) loader_i (
		.clk(clk),
		.rst(rst),
		.dma_data(dma_data),
		.dma_valid(dma_valid),
		.dma_last(dma_last),
		.dma_ready(dma_ready),
		.playing(playing),
		.mem(loader_mem.requester),
		.seg_count(seg_count),
		.wave_loaded(wave_loaded)
	);

	wave_player #(.BATCH_SIZE(BATCH_SIZE), .WAVE_DEPTH(WAVE_DEPTH)) player_i (
		.clk(clk),
		.rst(rst),
		.run(run),
		.halt(halt),
		.dac_rdy(dac_rdy),
		.seg_count(seg_count),
		.wave_loaded(wave_loaded),
		.mem(player_mem.requester),
		.playing(playing),
		.rdy_to_run(rdy_to_run),
		.batch_out(batch_out),
		.valid_batch_out(valid_batch_out)
	);

	wave_mem_arbiter #(.WAVE_DEPTH(WAVE_DEPTH)) arbiter_i (
		.clk(clk),
		.rst(rst),
		.player(player_mem.arbiter),
		.loader(loader_mem.arbiter),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata)
	);

	wave_ram #(.WAVE_DEPTH(WAVE_DEPTH)) ram_i (
		.clk(clk),
		.en(ram_en),
		.we(ram_we),
		.addr(ram_addr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

endmodule

// File: pwl_generator/wave_loader.sv
`timescale 1ns/1ps

module wave_loader #(
	parameter int WAVE_DEPTH = 32
) (
	input logic clk,
	input logic rst,
	input pwl_pkg::seg_word_t dma_data,
	input logic dma_valid,
	input logic dma_last,
	output logic dma_ready,
	input logic playing,
	wave_mem_if.requester mem,
	output logic [$clog2(WAVE_DEPTH):0] seg_count,
	output logic wave_loaded
);
	import pwl_pkg::*;

	localparam int AW = $clog2(WAVE_DEPTH);

	seg_word_t pend_word;
	logic pend_valid;
	logic pend_last;
	logic first_word;
	logic [AW-1:0] wr_addr;
	logic accept;
	logic written;

	// one word is buffered at a time, so the stream stalls until its write is granted.
	assign dma_ready = !pend_valid && !playing;
	assign accept = dma_valid && dma_ready;
	assign written = mem.req && mem.grant;

	assign mem.req = pend_valid;
	assign mem.we = 1'b1;
	assign mem.addr = wr_addr;
	assign mem.wdata = pend_word;

	always_ff @(posedge clk) begin
		if (rst) begin
			pend_valid <= 1'b0;
			pend_last <= 1'b0;
			first_word <= 1'b1;
			wr_addr <= '0;
			seg_count <= '0;
			wave_loaded <= 1'b0;
		end else begin
			if (accept) begin
				pend_valid <= 1'b1;
				pend_last <= dma_last;
				if (first_word) begin
					wr_addr <= '0; // a new wave starts over at the bottom of the memory.
					wave_loaded <= 1'b0;
					first_word <= 1'b0;
				end
			end
			if (written) begin
				pend_valid <= 1'b0;
				wr_addr <= wr_addr + 1'b1;
				if (pend_last) begin
					seg_count <= {1'b0, wr_addr} + 1'b1;
					wave_loaded <= 1'b1;
					first_word <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			pend_word <= dma_data;
	end

endmodule

// File: pwl_generator/wave_player.sv
`timescale 1ns/1ps

module wave_player #(
	parameter int BATCH_SIZE = 4,
	parameter int WAVE_DEPTH = 32
) (
	input logic clk,
	input logic rst,
	input logic run,
	input logic halt,
	input logic dac_rdy,
	input logic [$clog2(WAVE_DEPTH):0] seg_count,
	input logic wave_loaded,
	wave_mem_if.requester mem,
	output logic playing,
	output logic rdy_to_run,
	output pwl_pkg::sample_t [BATCH_SIZE-1:0] batch_out,
	output logic valid_batch_out
);
	import pwl_pkg::*;

	localparam int AW = $clog2(WAVE_DEPTH);

	typedef enum logic [2:0] {IDLE, FETCH, SEND, DRAIN, STOP} state_t;

	state_t state;
	logic [AW-1:0] rd_idx;
	seg_word_t nxt_word;
	seg_word_t src_word;
	logic nxt_valid;
	sample_t cur_x;
	slope_t cur_slope;
	dt_t cur_dt;
	sample_t step;
	logic [1:0] inflight;
	logic active;
	logic en;
	logic issue;
	logic need_new;
	logic take;

	assign active = (state == FETCH || state == SEND) && !halt;
	assign en = dac_rdy || !valid_batch_out;
	assign issue = state == SEND && !halt && en;
	assign need_new = state == FETCH || (issue && cur_dt == dt_t'(BATCH_SIZE));

	// the player always wins arbitration, so a read in flight shows up as rvalid.
	// at most one of nxt_valid and rvalid is set in any cycle.
	assign src_word = nxt_valid ? nxt_word : mem.rdata;
	assign take = active && need_new && (nxt_valid || mem.rvalid);
	assign step = sample_t'(cur_slope * BATCH_SIZE);

	assign mem.req = active && (!(nxt_valid || mem.rvalid) || take);
	assign mem.we = 1'b0;
	assign mem.addr = rd_idx;
	assign mem.wdata = '0;

	assign playing = state != IDLE;
	assign rdy_to_run = state == IDLE && wave_loaded;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			rd_idx <= '0;
			nxt_valid <= 1'b0;
			inflight <= '0;
		end else begin
			if (mem.req && mem.grant)
				rd_idx <= ({1'b0, rd_idx} == seg_count - 1'b1) ? '0 : rd_idx + 1'b1;

			if (active && mem.rvalid && !take)
				nxt_valid <= 1'b1;
			else if (take)
				nxt_valid <= 1'b0;

			case ({issue, valid_batch_out && dac_rdy})
				2'b10: inflight <= inflight + 1'b1;
				2'b01: inflight <= inflight - 1'b1;
				default: inflight <= inflight;
			endcase

			case (state)
				IDLE: begin
					if (run && wave_loaded)
						state <= FETCH;
				end
				FETCH: begin
					if (halt)
						state <= DRAIN;
					else if (take)
						state <= SEND;
				end
				SEND: begin
					if (halt)
						state <= DRAIN;
				end
				DRAIN: begin
					if (inflight == 2'd0)
						state <= STOP;
				end
				STOP: begin
					rd_idx <= '0; // a late read from before halt is dropped here.
					nxt_valid <= 1'b0;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (active && mem.rvalid && !take)
			nxt_word <= mem.rdata;
		if (take) begin
			cur_x <= seg_start(src_word);
			cur_slope <= seg_slope(src_word);
			cur_dt <= seg_dt(src_word);
		end else if (issue) begin
			cur_x <= cur_x + step;
			cur_dt <= cur_dt - dt_t'(BATCH_SIZE);
		end
	end

	interpolator #(.BATCH_SIZE(BATCH_SIZE)) interp_i (
		.clk(clk),
		.rst(rst),
		.en(en),
		.in_valid(issue),
		.x(cur_x),
		.slope(cur_slope),
		.out_valid(valid_batch_out),
		.batch(batch_out)
	);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the pwl_generator testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module pwl_generator_tb -f tb.f -o sim_pwl
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_pwl 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "TB PASSED"; then
	exit 0
else
	echo "simulation did not pass"
	exit 1
fi

// File: tb.f
common/pwl_pkg.sv
common/wave_mem_if.sv
verilog/wave_ram.sv
verilog/interpolator.sv
verilog/wave_mem_arbiter.sv
pwl_generator/wave_loader.sv
pwl_generator/wave_player.sv
pwl_generator/pwl_generator.sv
test/pwl_generator_assert.sv
test/pwl_generator_tb.sv

// File: test/pwl_generator_assert.sv
`timescale 1ns/1ps

module pwl_generator_assert #(
	parameter int BATCH_SIZE = 4
) (
	input logic clk,
	input logic rst,
	input logic dma_ready,
	input logic run,
	input logic dac_rdy,
	input logic rdy_to_run,
	input logic valid_batch_out,
	input pwl_pkg::sample_t [BATCH_SIZE-1:0] batch_out
);
	logic running;

	// set when run is taken and cleared once the player is ready again.
	always_ff @(posedge clk) begin
		if (rst)
			running <= 1'b0;
		else if (run && rdy_to_run)
			running <= 1'b1;
		else if (rdy_to_run)
			running <= 1'b0;
	end

	// a batch waiting on the DAC must not move.
	batch_held: assert property (@(posedge clk) disable iff (rst)
		valid_batch_out && !dac_rdy |=> valid_batch_out && $stable(batch_out))
		else $error("batch output changed while the DAC was not ready");

	no_load_while_playing: assert property (@(posedge clk) disable iff (rst)
		running && !rdy_to_run |-> !dma_ready)
		else $error("stream accepted words while the player was running");

	ready_or_valid: assert property (@(posedge clk) disable iff (rst)
		!(rdy_to_run && valid_batch_out))
		else $error("rdy_to_run and valid_batch_out were high together");

	reset_quiet: assert property (@(posedge clk)
		rst |=> !valid_batch_out && !rdy_to_run)
		else $error("an output flag was high right after reset");

endmodule

// File: test/pwl_generator_tb.sv
`timescale 1ns/1ps

module pwl_generator_tb;

	localparam int BATCH_SIZE = 4;
	localparam int WAVE_DEPTH = 32;
	localparam int MAX_SEGS = 8;
	localparam int MAX_RUN_BATCHES = 2 * MAX_SEGS * 4 + 8;
	localparam int TIMEOUT_CYCLES = 2000 * 2 * MAX_RUN_BATCHES + 16 + 2 * MAX_SEGS * 16;

	logic clk;
	logic rst;
	pwl_pkg::seg_word_t dma_data;
	logic dma_valid;
	logic dma_last;
	logic dma_ready;
	logic run;
	logic halt;
	logic dac_rdy = 1'b0;
	logic rdy_to_run;
	pwl_pkg::sample_t [BATCH_SIZE-1:0] batch_out;
	logic valid_batch_out;

	int seed = 32'h42882a65;
	pwl_pkg::seg_word_t wave_q[$];
	pwl_pkg::sample_t [BATCH_SIZE-1:0] model_q[$];
	int model_idx;
	int received;
	logic hold_pending = 1'b0;
	pwl_pkg::sample_t [BATCH_SIZE-1:0] held_batch;

	pwl_generator #(.BATCH_SIZE(BATCH_SIZE), .WAVE_DEPTH(WAVE_DEPTH)) pwl_generator_i (
		.clk(clk),
		.rst(rst),
		.dma_data(dma_data),
		.dma_valid(dma_valid),
		.dma_last(dma_last),
		.dma_ready(dma_ready),
		.run(run),
		.halt(halt),
		.dac_rdy(dac_rdy),
		.rdy_to_run(rdy_to_run),
		.batch_out(batch_out),
		.valid_batch_out(valid_batch_out)
	);

	bind pwl_generator pwl_generator_assert #(.BATCH_SIZE(BATCH_SIZE)) pwl_generator_assert_i (
		.clk(clk),
		.rst(rst),
		.dma_ready(dma_ready),
		.run(run),
		.dac_rdy(dac_rdy),
		.rdy_to_run(rdy_to_run),
		.valid_batch_out(valid_batch_out),
		.batch_out(batch_out)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TB FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic compare_batch(input pwl_pkg::sample_t [BATCH_SIZE-1:0] got,
			input pwl_pkg::sample_t [BATCH_SIZE-1:0] exp, input string name);
		if (got !== exp)
			abort_run($sformatf("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic compare_bit(input logic got, input logic exp, input string name);
		if (got !== exp)
			abort_run($sformatf("FAIL at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	// builds a random wave and expands it into the batches it should play.
	task automatic make_wave();
		pwl_pkg::sample_t start;
		pwl_pkg::slope_t slope;
		pwl_pkg::dt_t dt;
		pwl_pkg::sample_t [BATCH_SIZE-1:0] b;
		logic [31:0] acc;
		int n;
		int nb;
		wave_q.delete();
		model_q.delete();
		n = 3 + int'($unsigned($random(seed)) % 6);
		for (int i = 0; i < n; i++) begin
			start = pwl_pkg::sample_t'($random(seed));
			slope = pwl_pkg::slope_t'($random(seed));
			nb = 1 + int'($unsigned($random(seed)) % 4);
			dt = pwl_pkg::dt_t'(nb * BATCH_SIZE);
			wave_q.push_back({start, slope, dt});
			for (int j = 0; j < nb; j++) begin
				for (int k = 0; k < BATCH_SIZE; k++) begin
					acc = 32'(start) + 32'(j * BATCH_SIZE + k) * 32'(slope); // low 16 bits wrap.
					b[k] = acc[15:0];
				end
				model_q.push_back(b);
			end
		end
	endtask

	task automatic send_wave();
		int gap;
		for (int i = 0; i < wave_q.size(); i++) begin
			gap = int'($unsigned($random(seed)) % 3);
			repeat (gap) begin
				@(posedge clk);
				dma_valid <= 1'b0;
			end
			@(posedge clk);
			dma_valid <= 1'b1;
			dma_data <= wave_q[i];
			dma_last <= (i == wave_q.size() - 1);
			@(negedge clk);
			while (!dma_ready)
				@(negedge clk);
		end
		@(posedge clk);
		dma_valid <= 1'b0;
		dma_last <= 1'b0;
	endtask

	task automatic play_wave();
		int target;
		int at_halt;
		make_wave();
		send_wave();
		@(negedge clk);
		compare_bit(rdy_to_run, 1'b0, "rdy_to_run");
		while (!rdy_to_run)
			@(negedge clk);
		target = 2 * model_q.size() + int'($unsigned($random(seed)) % 8); // at least two passes.
		@(posedge clk);
		run <= 1'b1;
		model_idx = 0;
		received = 0;
		@(posedge clk);
		run <= 1'b0;
		while (received < target)
			@(posedge clk);
		halt <= 1'b1;
		at_halt = received;
		@(posedge clk);
		halt <= 1'b0;
		@(negedge clk);
		while (!rdy_to_run)
			@(negedge clk);
		compare_bit(valid_batch_out, 1'b0, "valid_batch_out");
		if (received - at_halt > 2)
			abort_run("more than two batches came out after halt");
		repeat (4) begin
			@(negedge clk);
			compare_bit(valid_batch_out, 1'b0, "valid_batch_out");
		end
	endtask

	always @(posedge clk)
		dac_rdy <= ($unsigned($random(seed)) % 3) != 0;

	// outputs are registered, so they are sampled half a cycle after the edge.
	always @(negedge clk) begin
		if (!rst) begin
			if (hold_pending) begin
				compare_bit(valid_batch_out, 1'b1, "valid_batch_out");
				compare_batch(batch_out, held_batch, "batch_out");
			end
			if (valid_batch_out && dac_rdy) begin
				if (model_q.size() == 0)
					abort_run("a batch came out while no wave was playing");
				compare_batch(batch_out, model_q[model_idx], "batch_out");
				model_idx = (model_idx + 1) % model_q.size();
				received++;
			end
			hold_pending = valid_batch_out && !dac_rdy;
			held_batch = batch_out;
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		abort_run("timeout, the DUT stopped making progress");
	end

	initial begin
		rst = 1'b1;
		dma_data = '0;
		dma_valid = 1'b0;
		dma_last = 1'b0;
		run = 1'b0;
		halt = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		compare_bit(rdy_to_run, 1'b0, "rdy_to_run");
		compare_bit(valid_batch_out, 1'b0, "valid_batch_out");
		compare_bit(dma_ready, 1'b1, "dma_ready");
		repeat (2) play_wave();
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: verilog/interpolator.sv
`timescale 1ns/1ps

module interpolator #(
	parameter int BATCH_SIZE = 4
) (
	input logic clk,
	input logic rst,
	input logic en,
	input logic in_valid,
	input pwl_pkg::sample_t x,
	input pwl_pkg::slope_t slope,
	output logic out_valid,
	output pwl_pkg::sample_t [BATCH_SIZE-1:0] batch
);
	import pwl_pkg::*;

	sample_t x_r;
	sample_t [BATCH_SIZE-1:0] prod_r;
	logic valid_r;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_r <= 1'b0;
			out_valid <= 1'b0;
		end else if (en) begin
			valid_r <= in_valid;
			out_valid <= valid_r;
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			x_r <= x;
			for (int k = 0; k < BATCH_SIZE; k++) begin
				prod_r[k] <= sample_t'(slope * k); // wraps modulo 2^16 like the sum below.
			end
			for (int k = 0; k < BATCH_SIZE; k++) begin
				batch[k] <= x_r + prod_r[k];
			end
		end
	end

endmodule

// File: verilog/wave_mem_arbiter.sv
`timescale 1ns/1ps

module wave_mem_arbiter #(
	parameter int WAVE_DEPTH = 32
) (
	input logic clk,
	input logic rst,
	wave_mem_if.arbiter player,
	wave_mem_if.arbiter loader,
	output logic ram_en,
	output logic ram_we,
	output logic [$clog2(WAVE_DEPTH)-1:0] ram_addr,
	output pwl_pkg::seg_word_t ram_wdata,
	input pwl_pkg::seg_word_t ram_rdata
);
	logic rd_player;
	logic rd_loader;

	// the player has fixed priority and never waits.
	assign player.grant = player.req;
	assign loader.grant = loader.req && !player.req;

	assign ram_en = player.req || loader.req;
	assign ram_we = player.req ? player.we : loader.we;
	assign ram_addr = player.req ? player.addr : loader.addr;
	assign ram_wdata = player.req ? player.wdata : loader.wdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_player <= 1'b0;
			rd_loader <= 1'b0;
		end else begin
			rd_player <= player.grant && !player.we;
			rd_loader <= loader.grant && !loader.we;
		end
	end

	assign player.rvalid = rd_player;
	assign player.rdata = rd_player ? ram_rdata : '0;
	assign loader.rvalid = rd_loader;
	assign loader.rdata = rd_loader ? ram_rdata : '0;

endmodule

// File: verilog/wave_ram.sv
`timescale 1ns/1ps

module wave_ram #(
	parameter int WAVE_DEPTH = 32
) (
	input logic clk,
	input logic en,
	input logic we,
	input logic [$clog2(WAVE_DEPTH)-1:0] addr,
	input pwl_pkg::seg_word_t wdata,
	output pwl_pkg::seg_word_t rdata
);
	import pwl_pkg::*;

	seg_word_t mem [WAVE_DEPTH];

	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr]; // read data lands one cycle later.
		end
	end

endmodule
